// File: design/fsb_pkg.sv
`default_nettype none

package fsb_pkg;

   // destination id carried in the top bits of every packet
   localparam int fsb_id_width_c = 4;

   // body is what remains after destid and the cmd flag
   localparam int fsb_body_width_c = 27;

   // data view split: tag in the upper bits, payload below
   localparam int fsb_seq_width_c  = 4;
   localparam int fsb_data_width_c = fsb_body_width_c - fsb_seq_width_c;

   // command view: opcode in the upper bits, rest unused
   localparam int fsb_opcode_width_c = 3;

   // switch opcodes
   // codes 0, 5, 6 and 7 are not assigned and get ignored by the gateway
   typedef enum logic [fsb_opcode_width_c-1:0] {
      fsb_op_enable        = 3'd1,
      fsb_op_disable       = 3'd2,
      fsb_op_reset_enable  = 3'd3,
      fsb_op_reset_disable = 3'd4
   } fsb_opcode_e;

   // body as seen by the node
   typedef struct packed {
      logic [fsb_seq_width_c-1:0]  seq;
      logic [fsb_data_width_c-1:0] data;
   } fsb_data_body_s;

   // body as seen by the gateway switch
   typedef struct packed {
      fsb_opcode_e                                    opcode;
      logic [fsb_body_width_c-fsb_opcode_width_c-1:0] unused;
   } fsb_cmd_body_s;

   // same 27 bits, decoded one way or the other depending on cmd
   typedef union packed {
      fsb_data_body_s data_view;
      fsb_cmd_body_s  cmd_view;
   } fsb_body_u;

   // full 32-bit bus packet, destid in the msbs
   typedef struct packed {
      logic [fsb_id_width_c-1:0] destid;
      // set for switch commands
      logic                      cmd;
      fsb_body_u                 body;
   } fsb_pkt_s;

endpackage

`default_nettype wire

// File: design/node_pkg.sv
`default_nettype none

package node_pkg;

   // accumulator widths on the node side
   localparam int node_count_width_c = 16;
   localparam int node_sum_width_c   = 32;
   // matches the tag field of the bus data view
   localparam int node_seq_width_c   = 4;

   // what the accumulating node exposes
   // 52 bits total
   typedef struct packed {
      // number of accepted data packets
      logic [node_count_width_c-1:0] count;
      // running sum of the data fields, wraps
      logic [node_sum_width_c-1:0]   sum;
      // tag of the most recent accepted packet
      logic [node_seq_width_c-1:0]   last_seq;
   } node_status_s;

endpackage

`default_nettype wire

// File: design/fsb_packet_source.sv
`default_nettype none

module fsb_packet_source
   (
      input  logic                                 clk_i,
      input  logic                                 reset_i,
      // request side, one-cycle strobe
      input  logic                                 send_i,
      input  logic [fsb_pkg::fsb_id_width_c-1:0]   dest_i,
      input  logic                                 cmd_i,
      input  fsb_pkg::fsb_body_u                   payload_i,
      // bus side
      output logic                                 v_o,
      output fsb_pkg::fsb_pkt_s                    pkt_o,
      input  logic                                 ready_i,
      output logic                                 ready_o
   );

   // one-entry holding register
   logic                                v_r;
   fsb_pkg::fsb_pkt_s                   pkt_r;
   fsb_pkg::fsb_pkt_s                   pkt_n;
   // running tag for data packets
   logic [fsb_pkg::fsb_seq_width_c-1:0] seq_r;
   logic                                accept;

   // free slot, or the held packet leaves this cycle
   assign ready_o = ~v_r | ready_i;
   assign accept  = send_i & ready_o;

   // assemble the outgoing word
   always_comb
   begin
      pkt_n.destid = dest_i;
      pkt_n.cmd    = cmd_i;
      pkt_n.body   = payload_i;
      // data packets get the tag stamped over the seq field
      // command bodies go out untouched
      if (!cmd_i)
      begin
         pkt_n.body.data_view.seq = seq_r;
      end
   end

   // valid and tag counter
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         v_r   <= 1'b0;
         seq_r <= '0;
      end
      else
      begin
         if (accept)
            v_r <= 1'b1;
         else if (ready_i)
            v_r <= 1'b0;
         // tag moves only on data, wraps at 16
         if (accept && !cmd_i)
            seq_r <= seq_r + 1'b1;
      end
   end

   // payload register, loaded on accept only
   always_ff @(posedge clk_i)
   begin
      if (accept)
         pkt_r <= pkt_n;
   end

   assign v_o   = v_r;
   assign pkt_o = pkt_r;

endmodule

`default_nettype wire

// File: design/fsb_fifo.sv
`default_nettype none

module fsb_fifo
   #(
      parameter int depth_p = 4
   )
   (
      input  logic              clk_i,
      input  logic              reset_i,
      // write side
      input  logic              v_i,
      input  fsb_pkg::fsb_pkt_s data_i,
      output logic              ready_o,
      // read side
      output logic              v_o,
      output fsb_pkg::fsb_pkt_s data_o,
      // pop, only raised while v_o is high
      input  logic              yumi_i
   );

   // pointer needs at least one bit even for a single entry
   localparam int ptr_width_lp   = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int count_width_lp = $clog2(depth_p + 1);

   // storage, no reset on the entries
   fsb_pkg::fsb_pkt_s mem_r [depth_p];

   logic [ptr_width_lp-1:0]   wr_ptr_r;
   logic [ptr_width_lp-1:0]   rd_ptr_r;
   logic [count_width_lp-1:0] count_r;
   logic                      push;
   logic                      pop;

   // full blocks the writer
   assign ready_o = (count_r != count_width_lp'(depth_p));
   assign v_o     = (count_r != '0);
   assign push    = v_i & ready_o;
   assign pop     = yumi_i;

   // head entry straight out of the array
   assign data_o = mem_r[rd_ptr_r];

   // write entry on push
   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= data_i;
   end

   // pointers and occupancy
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         // wrap at depth, depth need not be a power of two
         if (push)
         begin
            if (wr_ptr_r == ptr_width_lp'(depth_p - 1))
               wr_ptr_r <= '0;
            else
               wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         if (pop)
         begin
            if (rd_ptr_r == ptr_width_lp'(depth_p - 1))
               rd_ptr_r <= '0;
            else
               rd_ptr_r <= rd_ptr_r + 1'b1;
         end
         // simultaneous push and pop leaves the count alone
         if (push && !pop)
            count_r <= count_r + 1'b1;
         else if (pop && !push)
            count_r <= count_r - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: design/fsb_node_gateway.sv
`default_nettype none

module fsb_node_gateway
   #(
      // id this node answers to
      parameter int id_p               = 0,
      // node comes up enabled and its reset follows reset_i,
      // switch reset commands are then ignored
      parameter bit enabled_at_start_p = 1'b0
   )
   (
      input  logic              clk_i,
      input  logic              reset_i,
      // from the fifo
      input  logic              v_i,
      input  fsb_pkg::fsb_pkt_s data_i,
      // looks at v_i, so there is a v_i to ready_o path
      output logic              ready_o,
      // to the node, payload is data_i itself
      output logic              v_o,
      input  logic              ready_i,
      // switch state
      output logic              node_en_r_o,
      output logic              node_reset_r_o
   );

   logic node_en_r;
   logic node_en_n;
   logic node_reset_r;
   logic node_reset_n;
   logic id_match;
   logic for_this_node;
   logic for_switch;

   // classify the head packet
   assign id_match      = (data_i.destid == fsb_pkg::fsb_id_width_c'(id_p));
   assign for_this_node = v_i & id_match;
   // command addressed to us goes to the switch, never to the node
   assign for_switch    = for_this_node & data_i.cmd;

   // only node data, and only while awake
   assign v_o = node_en_r & for_this_node & ~for_switch;

   // sink the packet when
   // node asleep, node ready, switch command, or not ours
   // v_i guard keeps ready from floating ahead of valid
   assign ready_o = v_i
                    & (~node_en_r
                       | ready_i
                       | for_switch
                       | ~for_this_node);

   // switch command decode
   // opcode read through the command view of the body
   always_comb
   begin
      node_en_n    = node_en_r;
      node_reset_n = node_reset_r;
      // commands take effect on the transfer edge only
      if (for_switch && ready_o)
      begin
         case (data_i.body.cmd_view.opcode)
            fsb_pkg::fsb_op_enable:
               node_en_n = 1'b1;
            fsb_pkg::fsb_op_disable:
               node_en_n = 1'b0;
            fsb_pkg::fsb_op_reset_enable:
               node_reset_n = 1'b1;
            fsb_pkg::fsb_op_reset_disable:
               node_reset_n = 1'b0;
            default:
            begin
               // unassigned codes leave the switch alone
               node_en_n    = node_en_r;
               node_reset_n = node_reset_r;
            end
         endcase
      end
   end

   // enable starts low unless the node is enabled at start
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         node_en_r <= enabled_at_start_p;
      else
         node_en_r <= node_en_n;
   end

   // node reset held high out of reset so the node clears itself
   // with enabled_at_start_p it simply tracks reset_i
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         node_reset_r <= 1'b1;
      else if (enabled_at_start_p)
         node_reset_r <= 1'b0;
      else
         node_reset_r <= node_reset_n;
   end

   assign node_en_r_o    = node_en_r;
   assign node_reset_r_o = node_reset_r;

endmodule

`default_nettype wire

// File: design/fsb_accum_node.sv
`default_nettype none

module fsb_accum_node
   (
      input  logic                   clk_i,
      // node-level reset from the gateway switch
      input  logic                   node_reset_i,
      input  logic                   node_en_i,
      // data packets from the gateway
      input  logic                   v_i,
      input  fsb_pkg::fsb_pkt_s      data_i,
      // back-pressure from outside
      input  logic                   stall_i,
      output logic                   ready_o,
      output node_pkg::node_status_s status_o
   );

   node_pkg::node_status_s status_r;
   logic                   xfer;
   // data field widened to the sum width
   logic [node_pkg::node_sum_width_c-1:0] data_ext;
   // tag of the incoming packet
   logic [node_pkg::node_seq_width_c-1:0] seq_in;

   // not ready while stalled or held in reset
   assign ready_o = ~stall_i & ~node_reset_i;

   // the gateway only raises v_i when enabled,
   // node_en_i keeps a sleeping node from counting anyway
   assign xfer = v_i & ready_o & node_en_i;

   // read the body through its data view
   assign data_ext = node_pkg::node_sum_width_c'(data_i.body.data_view.data);
   assign seq_in   = data_i.body.data_view.seq;

   // accumulate on each transfer
   always_ff @(posedge clk_i)
   begin
      if (node_reset_i)
      begin
         status_r <= '0;
      end
      else if (xfer)
      begin
         // count and sum both wrap
         status_r.count    <= status_r.count + 1'b1;
         status_r.sum      <= status_r.sum + data_ext;
         status_r.last_seq <= seq_in;
      end
   end

   assign status_o = status_r;

endmodule

`default_nettype wire

// File: design/fsb_subsystem.sv
`default_nettype none

module fsb_subsystem
   #(
      parameter int id_p               = 5,
      parameter bit enabled_at_start_p = 1'b0,
      parameter int depth_p            = 4
   )
   (
      input  logic                               clk_i,
      input  logic                               reset_i,
      // request port
      input  logic                               send_i,
      input  logic [fsb_pkg::fsb_id_width_c-1:0] dest_i,
      input  logic                               cmd_i,
      input  fsb_pkg::fsb_body_u                 payload_i,
      // node back-pressure
      input  logic                               stall_i,
      output logic                               src_ready_o,
      output node_pkg::node_status_s             node_status_o,
      output logic                               node_en_o,
      output logic                               node_reset_o
   );

   // source to fifo
   logic              src_v;
   fsb_pkg::fsb_pkt_s src_pkt;
   logic              fifo_ready;
   // fifo to gateway
   logic              fifo_v;
   fsb_pkg::fsb_pkt_s fifo_pkt;
   logic              gw_yumi;
   // gateway to node
   logic              gw_v;
   logic              node_ready;
   logic              node_en;
   logic              node_reset;

   // packet source
   fsb_packet_source source
      (
         .clk_i     (clk_i),
         .reset_i   (reset_i),
         .send_i    (send_i),
         .dest_i    (dest_i),
         .cmd_i     (cmd_i),
         .payload_i (payload_i),
         .v_o       (src_v),
         .pkt_o     (src_pkt),
         .ready_i   (fifo_ready),
         .ready_o   (src_ready_o)
      );

   // buffering between source and gateway
   fsb_fifo #(.depth_p(depth_p)) fifo
      (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .v_i     (src_v),
         .data_i  (src_pkt),
         .ready_o (fifo_ready),
         .v_o     (fifo_v),
         .data_o  (fifo_pkt),
         .yumi_i  (gw_yumi)
      );

   // gateway ready already includes fifo_v, so it works as yumi
   fsb_node_gateway
      #(
         .id_p               (id_p),
         .enabled_at_start_p (enabled_at_start_p)
      )
      gateway
      (
         .clk_i          (clk_i),
         .reset_i        (reset_i),
         .v_i            (fifo_v),
         .data_i         (fifo_pkt),
         .ready_o        (gw_yumi),
         .v_o            (gw_v),
         .ready_i        (node_ready),
         .node_en_r_o    (node_en),
         .node_reset_r_o (node_reset)
      );

   // consumer, sees the fifo head word directly
   fsb_accum_node node
      (
         .clk_i        (clk_i),
         .node_reset_i (node_reset),
         .node_en_i    (node_en),
         .v_i          (gw_v),
         .data_i       (fifo_pkt),
         .stall_i      (stall_i),
         .ready_o      (node_ready),
         .status_o     (node_status_o)
      );

   assign node_en_o    = node_en;
   assign node_reset_o = node_reset;

endmodule

`default_nettype wire

// File: testbench/fsb_gateway_assertions.sv
`default_nettype none

module fsb_gateway_assertions
   (
      input logic clk_i,
      input logic reset_i,
      input logic v_i,
      input logic ready_o,
      input logic v_o,
      input logic node_en_r_o,
      input logic node_reset_r_o
   );

   // count of failed properties
   int unsigned failures = 0;

   // data reaches the node only while it is enabled
   node_data_needs_enable: assert property (@(posedge clk_i) disable iff (reset_i)
      v_o |-> node_en_r_o)
      else
      begin
         $error("gateway passed data to a disabled node");
         failures = failures + 1;
      end

   // ready never runs ahead of valid on the fifo side
   ready_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      ready_o |-> v_i)
      else
      begin
         $error("gateway raised ready without a valid packet");
         failures = failures + 1;
      end

   // node held in reset right after a bus reset
   reset_reaches_node: assert property (@(posedge clk_i)
      reset_i |=> node_reset_r_o)
      else
      begin
         $error("node reset not high in the cycle after reset_i");
         failures = failures + 1;
      end

endmodule

`default_nettype wire

// File: testbench/fsb_subsystem_tb.sv
`default_nettype none

module fsb_subsystem_tb;

   localparam int node_id_c = 5;
   localparam int depth_c   = 4;
   // cycles any single wait may take
   localparam int timeout_c = 200;

   logic                               clk_i;
   logic                               reset_i;
   logic                               send_i;
   logic [fsb_pkg::fsb_id_width_c-1:0] dest_i;
   logic                               cmd_i;
   fsb_pkg::fsb_body_u                 payload_i;
   logic                               stall_i;
   logic                               src_ready_o;
   node_pkg::node_status_s             node_status_o;
   logic                               node_en_o;
   logic                               node_reset_o;

   // reference model of the node status and the switch
   logic [15:0] exp_count;
   logic [31:0] exp_sum;
   logic [3:0]  exp_seq;
   logic        exp_en;
   logic        exp_reset;
   // tag the source stamps on its next data packet
   logic [3:0]  src_tag;

   fsb_subsystem #(.id_p(node_id_c), .enabled_at_start_p(1'b0), .depth_p(depth_c)) UUT
      (
         .clk_i         (clk_i),
         .reset_i       (reset_i),
         .send_i        (send_i),
         .dest_i        (dest_i),
         .cmd_i         (cmd_i),
         .payload_i     (payload_i),
         .stall_i       (stall_i),
         .src_ready_o   (src_ready_o),
         .node_status_o (node_status_o),
         .node_en_o     (node_en_o),
         .node_reset_o  (node_reset_o)
      );

   bind fsb_node_gateway fsb_gateway_assertions gateway_checks
      (
         .clk_i          (clk_i),
         .reset_i        (reset_i),
         .v_i            (v_i),
         .ready_o        (ready_o),
         .v_o            (v_o),
         .node_en_r_o    (node_en_r_o),
         .node_reset_r_o (node_reset_r_o)
      );

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic abort_with_failure();
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      abort_with_failure();
   endtask

   task automatic report_timeout(input string what);
      $display("gave up waiting for %s after %0d cycles at time %0t", what, timeout_c, $time);
      abort_with_failure();
   endtask

   // stop at the first failed gateway assertion
   always @(UUT.gateway.gateway_checks.failures)
   begin
      if (UUT.gateway.gateway_checks.failures != 0)
      begin
         $display("a gateway assertion failed at time %0t", $time);
         abort_with_failure();
      end
   end

   // inputs move a little after the rising edge
   task automatic next_cycle();
      @(posedge clk_i);
      #2;
   endtask

   task automatic wait_src_ready();
      int cycles;
      cycles = 0;
      while (src_ready_o !== 1'b1)
      begin
         if (cycles == timeout_c)
            report_timeout("src_ready_o");
         next_cycle();
         cycles++;
      end
   endtask

   // source register and fifo both empty means every packet has been handled
   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (UUT.src_v !== 1'b0 || UUT.fifo_v !== 1'b0)
      begin
         if (cycles == timeout_c)
            report_timeout("the packet path to drain");
         next_cycle();
         cycles++;
      end
   endtask

   task automatic wait_count(input logic [15:0] target);
      int cycles;
      cycles = 0;
      while (node_status_o.count !== target)
      begin
         if (cycles == timeout_c)
            report_timeout("the node count to settle");
         next_cycle();
         cycles++;
      end
   endtask

   task automatic send_packet(input logic [3:0] dest, input logic cmd,
                              input fsb_pkg::fsb_body_u body);
      wait_src_ready();
      send_i    = 1'b1;
      dest_i    = dest;
      cmd_i     = cmd;
      payload_i = body;
      next_cycle();
      send_i    = 1'b0;
   endtask

   // data packet that only an enabled node out of reset counts
   task automatic send_data(input logic [3:0] dest, input logic [22:0] value);
      fsb_pkg::fsb_body_u body;
      body.data_view.seq  = 4'h0;
      body.data_view.data = value;
      send_packet(dest, 1'b0, body);
      if (dest == node_id_c && exp_en && !exp_reset)
      begin
         exp_count = exp_count + 1'b1;
         exp_sum   = exp_sum + 32'(value);
         exp_seq   = src_tag;
      end
      // every accepted data send moves the tag whatever its destination
      src_tag = src_tag + 1'b1;
   endtask

   task automatic send_cmd(input logic [3:0] dest, input logic [2:0] op);
      fsb_pkg::fsb_body_u body;
      body.cmd_view.opcode = fsb_pkg::fsb_opcode_e'(op);
      body.cmd_view.unused = '0;
      send_packet(dest, 1'b1, body);
      if (dest == node_id_c)
      begin
         case (op)
            fsb_pkg::fsb_op_enable:
               exp_en = 1'b1;
            fsb_pkg::fsb_op_disable:
               exp_en = 1'b0;
            fsb_pkg::fsb_op_reset_enable:
            begin
               // node clears while held in reset
               exp_reset = 1'b1;
               exp_count = '0;
               exp_sum   = '0;
               exp_seq   = '0;
            end
            fsb_pkg::fsb_op_reset_disable:
               exp_reset = 1'b0;
            default:
            begin
               // unassigned opcodes leave the switch alone
            end
         endcase
      end
   endtask

   task automatic check_status();
      wait_count(exp_count);
      assert (node_status_o.count == exp_count)
         else report_mismatch("status count", 32'(node_status_o.count), 32'(exp_count));
      assert (node_status_o.sum == exp_sum)
         else report_mismatch("status sum", node_status_o.sum, exp_sum);
      assert (node_status_o.last_seq == exp_seq)
         else report_mismatch("status last_seq", 32'(node_status_o.last_seq), 32'(exp_seq));
   endtask

   task automatic check_switch();
      assert (node_en_o == exp_en)
         else report_mismatch("node_en_o", 32'(node_en_o), 32'(exp_en));
      assert (node_reset_o == exp_reset)
         else report_mismatch("node_reset_o", 32'(node_reset_o), 32'(exp_reset));
   endtask

   // node asleep after reset sinks its data
   task automatic test_after_reset();
      check_switch();
      // more sends than the fifo and the holding register can keep
      repeat (6)
         send_data(node_id_c, 23'($urandom()));
      wait_idle();
      check_status();
   endtask

   task automatic test_enable_and_count();
      send_cmd(node_id_c, fsb_pkg::fsb_op_reset_disable);
      send_cmd(node_id_c, fsb_pkg::fsb_op_enable);
      wait_idle();
      check_switch();
      // enough packets for the tag to wrap
      repeat (20)
         send_data(node_id_c, 23'($urandom()));
      check_status();
   endtask

   task automatic test_foreign_traffic();
      send_data(4'd3, 23'($urandom()));
      send_data(4'd12, 23'($urandom()));
      send_cmd(4'd7, fsb_pkg::fsb_op_disable);
      send_cmd(4'd0, fsb_pkg::fsb_op_reset_enable);
      // unassigned opcodes to this node
      send_cmd(node_id_c, 3'd6);
      send_cmd(node_id_c, 3'd0);
      // one counted packet shows the node is still awake
      send_data(node_id_c, 23'($urandom()));
      wait_idle();
      check_switch();
      check_status();
   endtask

   task automatic test_stall();
      int          sent;
      logic [15:0] held_count;
      sent       = 0;
      held_count = exp_count;
      stall_i    = 1'b1;
      while (src_ready_o)
      begin
         if (sent == 4 * depth_c)
         begin
            $display("src_ready_o never dropped while the node was stalled");
            abort_with_failure();
         end
         send_data(node_id_c, 23'($urandom()));
         sent++;
      end
      repeat (3)
         next_cycle();
      assert (src_ready_o == 1'b0)
         else report_mismatch("src_ready_o under stall", 32'(src_ready_o), 32'd0);
      // fifo entries plus the source holding register
      assert (sent == depth_c + 1)
         else report_mismatch("packets taken under stall", sent, depth_c + 1);
      assert (node_status_o.count == held_count)
         else report_mismatch("count under stall", 32'(node_status_o.count), 32'(held_count));
      stall_i = 1'b0;
      check_status();
   endtask

   task automatic test_disable_and_reset();
      send_cmd(node_id_c, fsb_pkg::fsb_op_disable);
      repeat (3)
         send_data(node_id_c, 23'($urandom()));
      wait_idle();
      check_switch();
      check_status();
      send_cmd(node_id_c, fsb_pkg::fsb_op_reset_enable);
      wait_idle();
      check_switch();
      check_status();
      send_cmd(node_id_c, fsb_pkg::fsb_op_reset_disable);
      send_cmd(node_id_c, fsb_pkg::fsb_op_enable);
      wait_idle();
      check_switch();
      repeat (4)
         send_data(node_id_c, 23'($urandom()));
      check_status();
   endtask

   initial
   begin
      void'($urandom(32'hb3cc_28da));
      reset_i   = 1'b1;
      send_i    = 1'b0;
      dest_i    = '0;
      cmd_i     = 1'b0;
      payload_i = '0;
      stall_i   = 1'b0;
      // model state after reset
      exp_count = '0;
      exp_sum   = '0;
      exp_seq   = '0;
      exp_en    = 1'b0;
      exp_reset = 1'b1;
      src_tag   = '0;
      repeat (3)
         @(posedge clk_i);
      #2;
      reset_i = 1'b0;
      test_after_reset();
      test_enable_and_count();
      test_foreign_traffic();
      test_stall();
      test_disable_and_reset();
      if (UUT.gateway.gateway_checks.failures == 0)
      begin
         $display("*** TEST PASSED ***");
         $finish;
      end
      else
      begin
         $display("gateway assertions failed during the run");
         abort_with_failure();
      end
   end

endmodule

`default_nettype wire

// File: files.f
design/fsb_pkg.sv
design/node_pkg.sv
design/fsb_packet_source.sv
design/fsb_fifo.sv
design/fsb_node_gateway.sv
design/fsb_accum_node.sv
design/fsb_subsystem.sv
testbench/fsb_gateway_assertions.sv
testbench/fsb_subsystem_tb.sv
